/* design/lane_cfg_pkg.sv */
// Lane dimensions and the element, register, length and address types
package lane_cfg_pkg;

  //////////////////////////////////////////////////////////////////////
  // Dimensions
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned ElemWidth = 32;
  localparam int unsigned NrVRegs   = 8;
  localparam int unsigned MaxVl     = 8;
  // Total element slots in the register file
  localparam int unsigned VrfDepth  = NrVRegs * MaxVl;

  //////////////////////////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////////////////////////

  typedef logic [ElemWidth-1:0]         elem_t;
  typedef logic [$clog2(NrVRegs)-1:0]   vreg_t;
  // Vector length, legal range 1 to MaxVl
  typedef logic [$clog2(MaxVl+1)-1:0]   vl_t;
  // Register index times MaxVl plus element index
  typedef logic [$clog2(VrfDepth)-1:0]  vrf_addr_t;

endpackage : lane_cfg_pkg

/* design/lane_op_pkg.sv */
// Lane operation codes, ALU functions and sequencer states
package lane_op_pkg;

  // Instruction opcodes seen on the request port
  typedef enum logic [2:0] {
    OP_ADD   = 3'd0,
    OP_SUB   = 3'd1,
    OP_AND   = 3'd2,
    OP_OR    = 3'd3,
    OP_XOR   = 3'd4,
    OP_MUL   = 3'd5,
    OP_STORE = 3'd6
  } lane_op_e;

  // Functions of the integer ALU
  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_XOR = 3'd4
  } alu_op_e;

  // Sequencer FSM
  typedef enum logic [1:0] {
    SEQ_IDLE  = 2'd0,
    SEQ_ISSUE = 2'd1,
    SEQ_DRAIN = 2'd2
  } seq_state_e;

endpackage : lane_op_pkg

/* design/vector_regfile.sv */
// Vector register file with two registered read ports and one write port
`timescale 1ns/10ps

module vector_regfile (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // Read ports
  input  lane_cfg_pkg::vrf_addr_t rd_addr_a_i,
  input  lane_cfg_pkg::vrf_addr_t rd_addr_b_i,
  output lane_cfg_pkg::elem_t     rd_data_a_o,
  output lane_cfg_pkg::elem_t     rd_data_b_o,
  // Write port
  input  logic                    wr_en_i,
  input  lane_cfg_pkg::vrf_addr_t wr_addr_i,
  input  lane_cfg_pkg::elem_t     wr_data_i
);

  import lane_cfg_pkg::*;

  // Flat storage indexed by register and element
  elem_t mem_q [VrfDepth];

  //////////////////////////////////////////////////////////////////////
  // Write port
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int unsigned i = 0; i < VrfDepth; i++) begin
        mem_q[i] <= '0;
      end
    end else if (wr_en_i) begin
      mem_q[wr_addr_i] <= wr_data_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Read ports
  //////////////////////////////////////////////////////////////////////

  // Data shows up the cycle after the address
  always_ff @(posedge clk_i) begin
    rd_data_a_o <= mem_q[rd_addr_a_i];
    rd_data_b_o <= mem_q[rd_addr_b_i];
  end

endmodule : vector_regfile

/* design/lane_sequencer.sv */
// Lane sequencer: request intake, element walk, unit dispatch and store stream
`timescale 1ns/10ps

module lane_sequencer (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // Instruction request
  input  logic                    req_valid_i,
  input  lane_op_pkg::lane_op_e   req_op_i,
  input  lane_cfg_pkg::vreg_t     req_vd_i,
  input  lane_cfg_pkg::vreg_t     req_vs1_i,
  input  lane_cfg_pkg::vreg_t     req_vs2_i,
  input  lane_cfg_pkg::vl_t       req_vl_i,
  output logic                    req_ready_o,
  output logic                    done_o,
  // Register file reads
  output lane_cfg_pkg::vrf_addr_t rd_addr_a_o,
  output lane_cfg_pkg::vrf_addr_t rd_addr_b_o,
  input  lane_cfg_pkg::elem_t     rd_data_a_i,
  input  lane_cfg_pkg::elem_t     rd_data_b_i,
  // Operand dispatch to the units
  output logic                    alu_valid_o,
  output lane_op_pkg::alu_op_e    alu_op_o,
  output logic                    mul_valid_o,
  output lane_cfg_pkg::elem_t     op_a_o,
  output lane_cfg_pkg::elem_t     op_b_o,
  output lane_cfg_pkg::vrf_addr_t op_addr_o,
  output logic                    op_last_o,
  // Last write-back of an arithmetic instruction
  input  logic                    wb_last_i,
  // Store stream
  output lane_cfg_pkg::elem_t     stu_operand_o,
  output logic                    stu_operand_valid_o,
  input  logic                    stu_operand_ready_i
);

  import lane_cfg_pkg::*;
  import lane_op_pkg::*;

  seq_state_e state_q;
  lane_op_e   op_q;
  vreg_t      vd_q;
  vreg_t      vs1_q;
  vreg_t      vs2_q;
  vl_t        vl_q;
  vl_t        idx_q;
  // Read in flight, its element index and last flag
  logic       pend_q;
  vl_t        pend_idx_q;
  logic       pend_last_q;
  // Store output register
  elem_t      stu_operand_q;
  logic       stu_valid_q;
  logic       stu_last_q;
  logic       done_q;

  logic       req_accept;
  logic       is_store;
  logic       is_mul;
  logic       last_elem;
  logic       issue;
  logic       stu_accept;

  function automatic vrf_addr_t elem_addr(vreg_t vreg, vl_t idx);
    return vrf_addr_t'(vreg) * vrf_addr_t'(MaxVl) + vrf_addr_t'(idx);
  endfunction

  assign req_ready_o = (state_q == SEQ_IDLE);
  assign req_accept  = req_valid_i & req_ready_o;
  assign is_store    = (op_q == OP_STORE);
  assign is_mul      = (op_q == OP_MUL);
  assign last_elem   = (idx_q == vl_q - vl_t'(1));
  assign stu_accept  = stu_valid_q & stu_operand_ready_i;

  // Stores only read when the output register is free on return
  assign issue = (state_q == SEQ_ISSUE) &&
                 (!is_store || (!pend_q && (!stu_valid_q || stu_operand_ready_i)));

  assign rd_addr_a_o = elem_addr(vs1_q, idx_q);
  assign rd_addr_b_o = elem_addr(vs2_q, idx_q);

  //////////////////////////////////////////////////////////////////////
  // Operand dispatch
  //////////////////////////////////////////////////////////////////////

  assign alu_valid_o = pend_q & !is_store & !is_mul;
  assign mul_valid_o = pend_q & is_mul;
  assign op_a_o      = rd_data_a_i;
  assign op_b_o      = rd_data_b_i;
  assign op_addr_o   = elem_addr(vd_q, pend_idx_q);
  assign op_last_o   = pend_last_q;

  always_comb begin
    case (op_q)
      OP_SUB:  alu_op_o = ALU_SUB;
      OP_AND:  alu_op_o = ALU_AND;
      OP_OR:   alu_op_o = ALU_OR;
      OP_XOR:  alu_op_o = ALU_XOR;
      default: alu_op_o = ALU_ADD;
    endcase
  end

  assign stu_operand_o       = stu_operand_q;
  assign stu_operand_valid_o = stu_valid_q;
  assign done_o              = done_q;

  //////////////////////////////////////////////////////////////////////
  // Control
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= SEQ_IDLE;
      idx_q       <= '0;
      pend_q      <= 1'b0;
      stu_valid_q <= 1'b0;
      done_q      <= 1'b0;
    end else begin
      pend_q <= issue;
      done_q <= 1'b0;
      if (issue) begin
        idx_q <= idx_q + vl_t'(1);
      end
      case (state_q)
        SEQ_IDLE: begin
          if (req_accept) begin
            state_q <= SEQ_ISSUE;
            idx_q   <= '0;
          end
        end
        SEQ_ISSUE: begin
          if (issue && last_elem) begin
            state_q <= SEQ_DRAIN;
          end
        end
        SEQ_DRAIN: begin
          // Store ends on the last handshake, arithmetic on its last write
          if (is_store ? (stu_accept && stu_last_q) : wb_last_i) begin
            state_q <= SEQ_IDLE;
            done_q  <= 1'b1;
          end
        end
        default: state_q <= SEQ_IDLE;
      endcase
      if (pend_q && is_store) begin
        stu_valid_q <= 1'b1;
      end else if (stu_accept) begin
        stu_valid_q <= 1'b0;
      end
    end
  end

  // Request fields and element payload
  always_ff @(posedge clk_i) begin
    if (req_accept) begin
      op_q  <= req_op_i;
      vd_q  <= req_vd_i;
      vs1_q <= req_vs1_i;
      vs2_q <= req_vs2_i;
      vl_q  <= req_vl_i;
    end
    if (issue) begin
      pend_idx_q  <= idx_q;
      pend_last_q <= last_elem;
    end
    if (pend_q && is_store) begin
      stu_operand_q <= rd_data_a_i;
      stu_last_q    <= pend_last_q;
    end
  end

endmodule : lane_sequencer

/* design/lane_alu.sv */
// Single-cycle integer ALU with registered result
`timescale 1ns/10ps

module lane_alu (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // Operands from the sequencer
  input  logic                    valid_i,
  input  lane_op_pkg::alu_op_e    op_i,
  input  lane_cfg_pkg::elem_t     a_i,
  input  lane_cfg_pkg::elem_t     b_i,
  input  lane_cfg_pkg::vrf_addr_t addr_i,
  input  logic                    last_i,
  // Result to the arbiter
  output logic                    res_valid_o,
  output lane_cfg_pkg::elem_t     res_o,
  output lane_cfg_pkg::vrf_addr_t res_addr_o,
  output logic                    res_last_o
);

  import lane_cfg_pkg::*;
  import lane_op_pkg::*;

  elem_t result;

  always_comb begin
    case (op_i)
      ALU_SUB: result = a_i - b_i;
      ALU_AND: result = a_i & b_i;
      ALU_OR:  result = a_i | b_i;
      ALU_XOR: result = a_i ^ b_i;
      default: result = a_i + b_i;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      res_valid_o <= 1'b0;
    end else begin
      res_valid_o <= valid_i;
    end
  end

  // Payload follows the strobe
  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      res_o      <= result;
      res_addr_o <= addr_i;
      res_last_o <= last_i;
    end
  end

endmodule : lane_alu

/* design/lane_mul.sv */
// Pipelined integer multiplier keeping the low product word
`timescale 1ns/10ps

module lane_mul #(
  parameter int unsigned MulStages = 2
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // Operands from the sequencer
  input  logic                    valid_i,
  input  lane_cfg_pkg::elem_t     a_i,
  input  lane_cfg_pkg::elem_t     b_i,
  input  lane_cfg_pkg::vrf_addr_t addr_i,
  input  logic                    last_i,
  // Result to the arbiter
  output logic                    res_valid_o,
  output lane_cfg_pkg::elem_t     res_o,
  output lane_cfg_pkg::vrf_addr_t res_addr_o,
  output logic                    res_last_o
);

  import lane_cfg_pkg::*;

  // Truncated to the element width
  elem_t     product;
  // One entry per stage, each may carry its own element
  logic      valid_q [MulStages];
  elem_t     prod_q  [MulStages];
  vrf_addr_t addr_q  [MulStages];
  logic      last_q  [MulStages];

  assign product = a_i * b_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int unsigned s = 0; s < MulStages; s++) begin
        valid_q[s] <= 1'b0;
      end
    end else begin
      valid_q[0] <= valid_i;
      for (int unsigned s = 1; s < MulStages; s++) begin
        valid_q[s] <= valid_q[s-1];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    prod_q[0] <= product;
    addr_q[0] <= addr_i;
    last_q[0] <= last_i;
    for (int unsigned s = 1; s < MulStages; s++) begin
      prod_q[s] <= prod_q[s-1];
      addr_q[s] <= addr_q[s-1];
      last_q[s] <= last_q[s-1];
    end
  end

  assign res_valid_o = valid_q[MulStages-1];
  assign res_o       = prod_q[MulStages-1];
  assign res_addr_o  = addr_q[MulStages-1];
  assign res_last_o  = last_q[MulStages-1];

endmodule : lane_mul

/* design/result_arbiter.sv */
// Write-back arbiter for ALU, multiplier and load results
`timescale 1ns/10ps

module result_arbiter (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // ALU result
  input  logic                    alu_valid_i,
  input  lane_cfg_pkg::elem_t     alu_res_i,
  input  lane_cfg_pkg::vrf_addr_t alu_addr_i,
  input  logic                    alu_last_i,
  // Multiplier result
  input  logic                    mul_valid_i,
  input  lane_cfg_pkg::elem_t     mul_res_i,
  input  lane_cfg_pkg::vrf_addr_t mul_addr_i,
  input  logic                    mul_last_i,
  // Load port
  input  logic                    ldu_req_i,
  input  lane_cfg_pkg::vrf_addr_t ldu_addr_i,
  input  lane_cfg_pkg::elem_t     ldu_wdata_i,
  output logic                    ldu_gnt_o,
  // Register file write port
  output logic                    wr_en_o,
  output lane_cfg_pkg::vrf_addr_t wr_addr_o,
  output lane_cfg_pkg::elem_t     wr_data_o,
  output logic                    wb_last_o
);

  logic wb_last_q;

  // Unit results first, the load only gets idle cycles
  assign ldu_gnt_o = ldu_req_i & !alu_valid_i & !mul_valid_i;
  assign wr_en_o   = alu_valid_i | mul_valid_i | ldu_req_i;

  always_comb begin
    if (alu_valid_i) begin
      wr_addr_o = alu_addr_i;
      wr_data_o = alu_res_i;
    end else if (mul_valid_i) begin
      wr_addr_o = mul_addr_i;
      wr_data_o = mul_res_i;
    end else begin
      wr_addr_o = ldu_addr_i;
      wr_data_o = ldu_wdata_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wb_last_q <= 1'b0;
    end else begin
      wb_last_q <= (alu_valid_i & alu_last_i) | (mul_valid_i & mul_last_i);
    end
  end

  assign wb_last_o = wb_last_q;

endmodule : result_arbiter

/* design/lane.sv */
// Vector lane top: sequencer, register file, ALU, multiplier and write-back arbiter
`timescale 1ns/10ps

module lane #(
  parameter int unsigned MulStages = 2
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // Instruction request
  input  logic                    req_valid_i,
  input  lane_op_pkg::lane_op_e   req_op_i,
  input  lane_cfg_pkg::vreg_t     req_vd_i,
  input  lane_cfg_pkg::vreg_t     req_vs1_i,
  input  lane_cfg_pkg::vreg_t     req_vs2_i,
  input  lane_cfg_pkg::vl_t       req_vl_i,
  output logic                    req_ready_o,
  output logic                    done_o,
  // Store stream
  output lane_cfg_pkg::elem_t     stu_operand_o,
  output logic                    stu_operand_valid_o,
  input  logic                    stu_operand_ready_i,
  // Load port
  input  logic                    ldu_req_i,
  input  lane_cfg_pkg::vrf_addr_t ldu_addr_i,
  input  lane_cfg_pkg::elem_t     ldu_wdata_i,
  output logic                    ldu_gnt_o
);

  import lane_cfg_pkg::*;
  import lane_op_pkg::*;

  // Register file reads
  vrf_addr_t rd_addr_a;
  vrf_addr_t rd_addr_b;
  elem_t     rd_data_a;
  elem_t     rd_data_b;
  // Operand dispatch
  logic      alu_valid;
  alu_op_e   alu_op;
  logic      mul_valid;
  elem_t     op_a;
  elem_t     op_b;
  vrf_addr_t op_addr;
  logic      op_last;
  // Unit results
  logic      alu_res_valid;
  elem_t     alu_res;
  vrf_addr_t alu_res_addr;
  logic      alu_res_last;
  logic      mul_res_valid;
  elem_t     mul_res;
  vrf_addr_t mul_res_addr;
  logic      mul_res_last;
  // Write-back
  logic      wr_en;
  vrf_addr_t wr_addr;
  elem_t     wr_data;
  logic      wb_last;

  lane_sequencer i_lane_sequencer (
    .clk_i, .rst_ni,
    .req_valid_i, .req_op_i, .req_vd_i, .req_vs1_i, .req_vs2_i, .req_vl_i,
    .req_ready_o, .done_o,
    .rd_addr_a_o (rd_addr_a), .rd_addr_b_o (rd_addr_b),
    .rd_data_a_i (rd_data_a), .rd_data_b_i (rd_data_b),
    .alu_valid_o (alu_valid), .alu_op_o    (alu_op),    .mul_valid_o (mul_valid),
    .op_a_o      (op_a),      .op_b_o      (op_b),
    .op_addr_o   (op_addr),   .op_last_o   (op_last),
    .wb_last_i   (wb_last),
    .stu_operand_o, .stu_operand_valid_o, .stu_operand_ready_i
  );

  vector_regfile i_vrf (
    .clk_i, .rst_ni,
    .rd_addr_a_i (rd_addr_a), .rd_addr_b_i (rd_addr_b),
    .rd_data_a_o (rd_data_a), .rd_data_b_o (rd_data_b),
    .wr_en_i     (wr_en),     .wr_addr_i   (wr_addr),   .wr_data_i (wr_data)
  );

  lane_alu i_alu (
    .clk_i, .rst_ni,
    .valid_i     (alu_valid),     .op_i       (alu_op),
    .a_i         (op_a),          .b_i        (op_b),
    .addr_i      (op_addr),       .last_i     (op_last),
    .res_valid_o (alu_res_valid), .res_o      (alu_res),
    .res_addr_o  (alu_res_addr),  .res_last_o (alu_res_last)
  );

  lane_mul #(
    .MulStages (MulStages)
  ) i_mul (
    .clk_i, .rst_ni,
    .valid_i     (mul_valid),
    .a_i         (op_a),          .b_i        (op_b),
    .addr_i      (op_addr),       .last_i     (op_last),
    .res_valid_o (mul_res_valid), .res_o      (mul_res),
    .res_addr_o  (mul_res_addr),  .res_last_o (mul_res_last)
  );

  result_arbiter i_result_arbiter (
    .clk_i, .rst_ni,
    .alu_valid_i (alu_res_valid), .alu_res_i  (alu_res),
    .alu_addr_i  (alu_res_addr),  .alu_last_i (alu_res_last),
    .mul_valid_i (mul_res_valid), .mul_res_i  (mul_res),
    .mul_addr_i  (mul_res_addr),  .mul_last_i (mul_res_last),
    .ldu_req_i, .ldu_addr_i, .ldu_wdata_i, .ldu_gnt_o,
    .wr_en_o     (wr_en),         .wr_addr_o  (wr_addr),
    .wr_data_o   (wr_data),       .wb_last_o  (wb_last)
  );

endmodule : lane

/* verification/lane_tb.sv */
// Lane testbench: clock, reset, register file model, check task and directed tests
`timescale 1ns/10ps

module lane_tb;

  import lane_cfg_pkg::*;
  import lane_op_pkg::*;

  localparam int unsigned MulStages = 3;
  // Cycles that any single wait may take
  localparam int unsigned Timeout   = 200;

  logic      clk;
  logic      rst_n;
  logic      req_valid;
  lane_op_e  req_op;
  vreg_t     req_vd;
  vreg_t     req_vs1;
  vreg_t     req_vs2;
  vl_t       req_vl;
  logic      req_ready;
  logic      done;
  elem_t     stu_operand;
  logic      stu_operand_valid;
  logic      stu_operand_ready;
  logic      ldu_req;
  vrf_addr_t ldu_addr;
  elem_t     ldu_wdata;
  logic      ldu_gnt;

  // Expected register file contents
  elem_t model_vrf [VrfDepth];

  lane #(
    .MulStages (MulStages)
  ) UUT (
    .clk_i               (clk),
    .rst_ni              (rst_n),
    .req_valid_i         (req_valid),
    .req_op_i            (req_op),
    .req_vd_i            (req_vd),
    .req_vs1_i           (req_vs1),
    .req_vs2_i           (req_vs2),
    .req_vl_i            (req_vl),
    .req_ready_o         (req_ready),
    .done_o              (done),
    .stu_operand_o       (stu_operand),
    .stu_operand_valid_o (stu_operand_valid),
    .stu_operand_ready_i (stu_operand_ready),
    .ldu_req_i           (ldu_req),
    .ldu_addr_i          (ldu_addr),
    .ldu_wdata_i         (ldu_wdata),
    .ldu_gnt_o           (ldu_gnt)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // Checking and reference rules
  //////////////////////////////////////////////////////////////////////

  task automatic abort_run();
    $display("Test failed");
    $fatal(1, "Simulation stopped after an error");
  endtask

  task automatic check(input elem_t actual, input elem_t expected, input string what);
    if (actual !== expected) begin
      $display("Mismatch at %0t: %s, got 0x%08h, expected 0x%08h",
               $time, what, actual, expected);
      abort_run();
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Error at %0t: timed out waiting for %s", $time, what);
    abort_run();
  endtask

  // Register index times MaxVl plus element index
  function automatic vrf_addr_t addr_of(input int unsigned vreg, input int unsigned idx);
    return vrf_addr_t'(vreg * MaxVl + idx);
  endfunction

  function automatic elem_t expected_result(input lane_op_e op, input elem_t a, input elem_t b);
    logic [2*ElemWidth-1:0] product;
    product = {{ElemWidth{1'b0}}, a} * {{ElemWidth{1'b0}}, b};
    case (op)
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_AND:  return a & b;
      OP_OR:   return a | b;
      OP_XOR:  return a ^ b;
      OP_MUL:  return product[ElemWidth-1:0];
      default: return '0;
    endcase
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Bus tasks
  //////////////////////////////////////////////////////////////////////

  task automatic send_request(input lane_op_e op, input int unsigned vd,
                              input int unsigned vs1, input int unsigned vs2,
                              input int unsigned vl);
    int unsigned waited = 0;
    logic        seen   = 1'b0;
    @(posedge clk);
    #2;
    req_valid = 1'b1;
    req_op    = op;
    req_vd    = vreg_t'(vd);
    req_vs1   = vreg_t'(vs1);
    req_vs2   = vreg_t'(vs2);
    req_vl    = vl_t'(vl);
    while (!seen && waited < Timeout) begin
      @(negedge clk);
      seen = req_ready;
      waited++;
    end
    if (!seen) begin
      report_timeout("req_ready_o");
    end
    @(posedge clk);
    #2;
    req_valid = 1'b0;
  endtask

  task automatic wait_done();
    int unsigned waited = 0;
    logic        seen   = 1'b0;
    while (!seen && waited < Timeout) begin
      @(negedge clk);
      seen = done;
      waited++;
    end
    if (!seen) begin
      report_timeout("done_o");
    end
  endtask

  // Also makes sure done does not show up early
  task automatic wait_store_valid();
    int unsigned waited = 0;
    logic        seen   = 1'b0;
    while (!seen && waited < Timeout) begin
      @(negedge clk);
      check(elem_t'(done), elem_t'(0), "done_o before last store element");
      seen = stu_operand_valid;
      waited++;
    end
    if (!seen) begin
      report_timeout("stu_operand_valid_o");
    end
  endtask

  task automatic load_word(input vrf_addr_t addr, input elem_t data);
    int unsigned waited = 0;
    logic        seen   = 1'b0;
    @(posedge clk);
    #2;
    ldu_req   = 1'b1;
    ldu_addr  = addr;
    ldu_wdata = data;
    while (!seen && waited < Timeout) begin
      @(negedge clk);
      seen = ldu_gnt;
      waited++;
    end
    if (!seen) begin
      report_timeout("ldu_gnt_o");
    end
    // Write lands on the edge that closes the grant cycle
    @(posedge clk);
    #2;
    ldu_req = 1'b0;
    model_vrf[addr] = data;
  endtask

  task automatic run_arith(input lane_op_e op, input int unsigned vd,
                           input int unsigned vs1, input int unsigned vs2,
                           input int unsigned vl);
    elem_t result [MaxVl];
    // Sources taken before the write, vd may alias them
    for (int unsigned i = 0; i < vl; i++) begin
      result[i] = expected_result(op, model_vrf[addr_of(vs1, i)], model_vrf[addr_of(vs2, i)]);
    end
    send_request(op, vd, vs1, vs2, vl);
    wait_done();
    for (int unsigned i = 0; i < vl; i++) begin
      model_vrf[addr_of(vd, i)] = result[i];
    end
  endtask

  // Stall cycles of zero keep ready high all along
  task automatic store_and_compare(input int unsigned vreg, input int unsigned vl,
                                   input int unsigned stall);
    elem_t data;
    @(posedge clk);
    #2;
    stu_operand_ready = (stall == 0);
    send_request(OP_STORE, 0, vreg, 0, vl);
    for (int unsigned i = 0; i < vl; i++) begin
      wait_store_valid();
      data = stu_operand;
      check(data, model_vrf[addr_of(vreg, i)], $sformatf("store v%0d element %0d", vreg, i));
      if (stall != 0) begin
        repeat (stall) begin
          @(negedge clk);
          check(elem_t'(stu_operand_valid), elem_t'(1), "stu_operand_valid_o while stalled");
          check(stu_operand, data, "stu_operand_o while stalled");
          check(elem_t'(done), elem_t'(0), "done_o while stalled");
        end
        @(posedge clk);
        #2;
        stu_operand_ready = 1'b1;
        @(negedge clk);
        check(stu_operand, data, "stu_operand_o at acceptance");
        @(posedge clk);
        #2;
        stu_operand_ready = 1'b0;
      end
    end
    wait_done();
    check(elem_t'(stu_operand_valid), elem_t'(0), "stu_operand_valid_o after done_o");
  endtask

  //////////////////////////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_reset_state();
    @(negedge clk);
    check(elem_t'(req_ready), elem_t'(1), "req_ready_o after reset");
    check(elem_t'(done), elem_t'(0), "done_o after reset");
    check(elem_t'(stu_operand_valid), elem_t'(0), "stu_operand_valid_o after reset");
    check(elem_t'(ldu_gnt), elem_t'(0), "ldu_gnt_o after reset");
    store_and_compare(3, MaxVl, 0);
  endtask

  task automatic test_load_port();
    for (int unsigned r = 0; r < NrVRegs; r++) begin
      for (int unsigned i = 0; i < MaxVl; i++) begin
        load_word(addr_of(r, i), $urandom());
      end
      store_and_compare(r, MaxVl, 0);
    end
  endtask

  task automatic test_alu_ops();
    lane_op_e    ops [5] = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR};
    int unsigned vd;
    for (int unsigned k = 0; k < 5; k++) begin
      repeat (3) begin
        vd = $urandom_range(0, NrVRegs - 1);
        run_arith(ops[k], vd, $urandom_range(0, NrVRegs - 1),
                  $urandom_range(0, NrVRegs - 1), $urandom_range(1, MaxVl));
        store_and_compare(vd, MaxVl, 0);
      end
    end
  endtask

  task automatic test_mul();
    run_arith(OP_MUL, 4, 0, 1, MaxVl);
    store_and_compare(4, MaxVl, 0);
    // Destination aliases one source
    run_arith(OP_MUL, 5, 5, 2, $urandom_range(1, MaxVl));
    store_and_compare(5, MaxVl, 0);
    run_arith(OP_MUL, 6, 3, 6, $urandom_range(1, MaxVl));
    store_and_compare(6, MaxVl, 0);
    // Squares in place
    run_arith(OP_MUL, 1, 1, 1, MaxVl);
    store_and_compare(1, MaxVl, 0);
  endtask

  task automatic test_store_backpressure();
    store_and_compare(2, MaxVl, 3);
    store_and_compare(6, 5, 1);
  endtask

  task automatic test_load_during_mul();
    elem_t     value;
    vrf_addr_t addr;
    value = $urandom();
    addr  = addr_of(7, 3);
    fork
      run_arith(OP_MUL, 2, 0, 1, MaxVl);
      begin
        // Lands while products are being written back
        repeat (MulStages + 4) @(posedge clk);
        load_word(addr, value);
      end
    join
    store_and_compare(2, MaxVl, 0);
    store_and_compare(7, MaxVl, 0);
  endtask

  initial begin
    void'($urandom(32'h67ba_188f));
    rst_n             = 1'b0;
    req_valid         = 1'b0;
    req_op            = OP_ADD;
    req_vd            = '0;
    req_vs1           = '0;
    req_vs2           = '0;
    req_vl            = vl_t'(1);
    stu_operand_ready = 1'b0;
    ldu_req           = 1'b0;
    ldu_addr          = '0;
    ldu_wdata         = '0;
    for (int unsigned i = 0; i < VrfDepth; i++) begin
      model_vrf[i] = '0;
    end
    repeat (10) @(posedge clk);
    #2;
    rst_n = 1'b1;

    test_reset_state();
    test_load_port();
    test_alu_ops();
    test_mul();
    test_store_backpressure();
    test_load_during_mul();

    $display("Test passed");
    $finish;
  end

endmodule : lane_tb

/* lane.f */
design/lane_cfg_pkg.sv
design/lane_op_pkg.sv
design/vector_regfile.sv
design/lane_sequencer.sv
design/lane_alu.sv
design/lane_mul.sv
design/result_arbiter.sv
design/lane.sv
verification/lane_tb.sv

/* run.sh */
#!/bin/sh
# Build the lane testbench with Verilator, run it and search the log for the result
rm -f sim.log
verilator --binary --timing -f lane.f --top-module lane_tb -o lane_sim \
  && ./obj_dir/lane_sim 2>&1 | tee sim.log \
  || echo "Build or simulation did not complete"
grep -q "^Test passed$" sim.log \
  && echo "PASS" \
  || { echo "FAIL"; exit 1; }
